/* verilog/pwr_seq_pkg.sv */
/*
 * Shared types, register map and default timer limits of the power sequencer.
 * Rail count is fixed at 15. Both timers use 24-bit counters, so a limit above
 * 2^24-1 cannot be represented.
 */
`default_nettype none

package pwr_seq_pkg;

	localparam int rail_count = 15;

	typedef logic [rail_count-1:0] rail_vec_t;
	typedef logic [7:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;
	typedef logic [23:0] count_t;

	// Register map
	localparam reg_addr_t addr_version = 8'h00;
	localparam reg_addr_t addr_clear = 8'h03;
	localparam reg_addr_t addr_pg_hi = 8'h05;
	localparam reg_addr_t addr_pg_lo = 8'h06;
	localparam reg_addr_t addr_status = 8'h07;
	localparam reg_addr_t addr_vendor = 8'h0C;

	// Identity bytes with vendor_id[0] at addr_vendor
	localparam reg_data_t fpga_version = 8'h06;
	localparam logic [3:0][7:0] vendor_id = {8'h20, 8'h53, 8'h43, 8'h52};
	localparam reg_data_t clear_readback = 8'hFF;

	// Hardware timer limits in clk_in cycles
	localparam count_t default_delay_cycles = 24'd65536;
	localparam count_t default_watch_cycles = 24'd8388608;

	typedef struct packed {
		logic sysen;
		rail_vec_t pg;
	} sync_in_t;

	typedef struct packed {
		logic wait_err;
		logic operation_err;
		logic fault;
	} fault_t;

	typedef struct packed {
		logic [2:0] rsvd;
		logic wait_err;
		logic operation_err;
		logic fault;
		logic sysen;
		logic sysgood;
	} status_t;

endpackage

`default_nettype wire

/* verilog/rail_sequencer.sv */
/*
 * Two-flop synchronizer for sysen and pg, then the registered enable chain.
 * Rails come up in index order and go down as the rail above loses pg.
 * A set fault forces every enable low on the next edge.
 */
`timescale 1ns/1ps
`default_nettype none

module rail_sequencer #(
	parameter type sync_t = pwr_seq_pkg::sync_in_t
) (
	input wire logic clk_in,
	input wire logic arst_n,
	input wire logic sysen,
	input wire pwr_seq_pkg::rail_vec_t pg,
	input wire pwr_seq_pkg::rail_vec_t done,
	input wire pwr_seq_pkg::fault_t errs,
	output pwr_seq_pkg::sync_in_t sync,
	output pwr_seq_pkg::rail_vec_t en
);

	localparam int last = pwr_seq_pkg::rail_count - 1;

	sync_t meta_q;
	sync_t sync_q;
	pwr_seq_pkg::rail_vec_t en_next;

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			meta_q <= '0;
			sync_q <= '0;
		end else begin
			meta_q <= sync_t'({sysen, pg});
			sync_q <= meta_q;
		end
	end

	assign sync = sync_q;

	// Up by done of the rail below, held up by pg of the rail above
	always_comb begin
		en_next[0] = sync.sysen | sync.pg[1];
		for (int i = 1; i < last; i++) begin
			en_next[i] = (sync.sysen & done[i-1]) | sync.pg[i+1];
		end
		en_next[last] = sync.sysen & done[last-1];
		if (errs.fault) begin
			en_next = '0;
		end
	end

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			en <= '0;
		end else begin
			en <= en_next;
		end
	end

	a_fault_rails_off: assert property (@(posedge clk_in) disable iff (!arst_n)
		errs.fault |=> (en == '0));

endmodule

`default_nettype wire

/* verilog/rail_timer.sv */
/*
 * Shared settle-delay and watchdog counters with lowest-rail priority.
 * Only one rail settles or is watched at a time, so a higher rail waits
 * while a lower one is busy. done clears when sysen drops or on a fault.
 */
`timescale 1ns/1ps
`default_nettype none

module rail_timer #(
	parameter pwr_seq_pkg::count_t delay_cycles = pwr_seq_pkg::default_delay_cycles,
	parameter pwr_seq_pkg::count_t watch_cycles = pwr_seq_pkg::default_watch_cycles
) (
	input wire logic clk_in,
	input wire logic arst_n,
	input wire pwr_seq_pkg::sync_in_t sync,
	input wire pwr_seq_pkg::rail_vec_t en,
	input wire pwr_seq_pkg::fault_t errs,
	input wire logic clear_err,
	output pwr_seq_pkg::rail_vec_t done,
	output logic wait_timeout
);

	pwr_seq_pkg::count_t d_count;
	pwr_seq_pkg::count_t w_count;

	// Rails with good pg still settling, and rails enabled without pg
	pwr_seq_pkg::rail_vec_t settle_hit;
	pwr_seq_pkg::rail_vec_t settle_sel;
	pwr_seq_pkg::rail_vec_t watch_hit;

	assign settle_hit = en & sync.pg & ~done;
	assign watch_hit = en & ~sync.pg;

	// Isolate the lowest set bit
	assign settle_sel = settle_hit & (~settle_hit + 1'b1);

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			d_count <= '0;
			w_count <= '0;
			done <= '0;
			wait_timeout <= 1'b0;
		end else begin
			wait_timeout <= 1'b0;
			if (clear_err) begin
				d_count <= '0;
				w_count <= '0;
			end else if (!sync.sysen || errs.fault) begin
				d_count <= '0;
				w_count <= '0;
				done <= '0;
			end else if (|settle_hit) begin
				// Watchdog restarts for each rail
				w_count <= '0;
				if (d_count == delay_cycles) begin
					d_count <= '0;
					done <= done | settle_sel;
				end else begin
					d_count <= d_count + 1'b1;
				end
			end else if (|watch_hit) begin
				if (w_count == watch_cycles) begin
					w_count <= '0;
					wait_timeout <= 1'b1;
				end else begin
					w_count <= w_count + 1'b1;
				end
			end
		end
	end

	// done is always a run of ones starting at rail 0
	a_done_contiguous: assert property (@(posedge clk_in) disable iff (!arst_n)
		(done & (done + 1'b1)) == '0);

endmodule

`default_nettype wire

/* verilog/fault_monitor.sv */
/*
 * Error latches and summary fault. clear_err wins over every set condition.
 * An operation error is a done rail whose synchronized pg has gone low.
 * sysgood follows done of the last rail one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

module fault_monitor (
	input wire logic clk_in,
	input wire logic arst_n,
	input wire pwr_seq_pkg::sync_in_t sync,
	input wire pwr_seq_pkg::rail_vec_t done,
	input wire logic wait_timeout,
	input wire logic clear_err,
	output pwr_seq_pkg::fault_t errs,
	output logic sysgood
);

	logic rail_lost;

	assign rail_lost = |(done & ~sync.pg);

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			errs <= '0;
		end else if (clear_err) begin
			errs <= '0;
		end else begin
			if (wait_timeout) begin
				errs.wait_err <= 1'b1;
			end
			if (rail_lost) begin
				errs.operation_err <= 1'b1;
			end
			// Summary lags the causes by one clock
			if (errs.wait_err || errs.operation_err) begin
				errs.fault <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			sysgood <= 1'b0;
		end else begin
			sysgood <= done[pwr_seq_pkg::rail_count-1];
		end
	end

	a_fault_has_cause: assert property (@(posedge clk_in) disable iff (!arst_n)
		$rose(errs.fault) |-> $past(errs.wait_err | errs.operation_err));

endmodule

`default_nettype wire

/* verilog/seq_regs.sv */
/*
 * Byte-wide register port. wr_valid loads the pointer, rd_req increments it.
 * rd_data is registered from the pointer every clock, unmapped reads give 0.
 * Writing addr_clear pulses clear_err for one cycle, two edges later.
 */
`timescale 1ns/1ps
`default_nettype none

module seq_regs (
	input wire logic clk_in,
	input wire logic arst_n,
	input wire logic wr_valid,
	input wire pwr_seq_pkg::reg_addr_t wr_data,
	input wire logic rd_req,
	input wire pwr_seq_pkg::sync_in_t sync,
	input wire pwr_seq_pkg::fault_t errs,
	input wire logic sysgood,
	output pwr_seq_pkg::reg_data_t rd_data,
	output logic clear_err
);

	pwr_seq_pkg::reg_addr_t ptr;
	pwr_seq_pkg::rail_vec_t pg_snap;
	pwr_seq_pkg::status_t status;
	logic [1:0] clr_pipe;

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			ptr <= '0;
		end else if (wr_valid) begin
			ptr <= wr_data;
		end else if (rd_req) begin
			ptr <= ptr + 1'b1;
		end
	end

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			clr_pipe <= '0;
			clear_err <= 1'b0;
		end else begin
			clr_pipe <= {clr_pipe[0], wr_valid && (wr_data == pwr_seq_pkg::addr_clear)};
			clear_err <= clr_pipe[1];
		end
	end

	// Snapshot holds the pg state from before the fault
	always_ff @(posedge clk_in) begin
		if (!errs.fault) begin
			pg_snap <= sync.pg;
		end
	end

	assign status = '{
		rsvd: 3'b000,
		wait_err: errs.wait_err,
		operation_err: errs.operation_err,
		fault: errs.fault,
		sysen: sync.sysen,
		sysgood: sysgood
	};

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			rd_data <= '0;
		end else begin
			case (ptr)
				pwr_seq_pkg::addr_version: rd_data <= pwr_seq_pkg::fpga_version;
				pwr_seq_pkg::addr_clear: rd_data <= pwr_seq_pkg::clear_readback;
				pwr_seq_pkg::addr_pg_hi: rd_data <= {1'b0, pg_snap[14:8]};
				pwr_seq_pkg::addr_pg_lo: rd_data <= pg_snap[7:0];
				pwr_seq_pkg::addr_status: rd_data <= status;
				pwr_seq_pkg::addr_vendor: rd_data <= pwr_seq_pkg::vendor_id[0];
				pwr_seq_pkg::addr_vendor + 8'd1: rd_data <= pwr_seq_pkg::vendor_id[1];
				pwr_seq_pkg::addr_vendor + 8'd2: rd_data <= pwr_seq_pkg::vendor_id[2];
				pwr_seq_pkg::addr_vendor + 8'd3: rd_data <= pwr_seq_pkg::vendor_id[3];
				default: rd_data <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/pwr_seq_top.sv */
/*
 * Board power sequencer core, single clock domain on clk_in.
 * sysen and pg are asynchronous levels and are synchronized inside.
 * Register port strobes are one cycle wide and are never back-pressured.
 */
`timescale 1ns/1ps
`default_nettype none

module pwr_seq_top #(
	parameter pwr_seq_pkg::count_t delay_cycles = pwr_seq_pkg::default_delay_cycles,
	parameter pwr_seq_pkg::count_t watch_cycles = pwr_seq_pkg::default_watch_cycles
) (
	input wire logic clk_in,
	input wire logic arst_n,
	input wire logic sysen,
	input wire pwr_seq_pkg::rail_vec_t pg,
	input wire logic wr_valid,
	input wire pwr_seq_pkg::reg_addr_t wr_data,
	input wire logic rd_req,
	output pwr_seq_pkg::reg_data_t rd_data,
	output pwr_seq_pkg::rail_vec_t en,
	output logic sysgood
);

	pwr_seq_pkg::sync_in_t sync;
	pwr_seq_pkg::rail_vec_t done;
	pwr_seq_pkg::fault_t errs;
	logic wait_timeout;
	logic clear_err;

	rail_sequencer seq0 (
		.clk_in(clk_in),
		.arst_n(arst_n),
		.sysen(sysen),
		.pg(pg),
		.done(done),
		.errs(errs),
		.sync(sync),
		.en(en)
	);

	rail_timer #(
		.delay_cycles(delay_cycles),
		.watch_cycles(watch_cycles)
	) timer0 (
		.clk_in(clk_in),
		.arst_n(arst_n),
		.sync(sync),
		.en(en),
		.errs(errs),
		.clear_err(clear_err),
		.done(done),
		.wait_timeout(wait_timeout)
	);

	fault_monitor mon0 (
		.clk_in(clk_in),
		.arst_n(arst_n),
		.sync(sync),
		.done(done),
		.wait_timeout(wait_timeout),
		.clear_err(clear_err),
		.errs(errs),
		.sysgood(sysgood)
	);

	seq_regs regs0 (
		.clk_in(clk_in),
		.arst_n(arst_n),
		.wr_valid(wr_valid),
		.wr_data(wr_data),
		.rd_req(rd_req),
		.sync(sync),
		.errs(errs),
		.sysgood(sysgood),
		.rd_data(rd_data),
		.clear_err(clear_err)
	);

endmodule

`default_nettype wire

/* sim/pwr_seq_tb.sv */
/*
 * Testbench for pwr_seq_top with short timers (delay 8, watch 64 cycles).
 * The supply model raises pg 2 to 20 cycles after en, with LCG delays.
 * Stops with $fatal at the first mismatch, or at the cycle limit.
 */
`timescale 1ns/1ps
`default_nettype none

module pwr_seq_tb;

	localparam int delay_cycles = 8;
	localparam int watch_cycles = 64;
	localparam int timeout_cycles = 6 * pwr_seq_pkg::rail_count * (watch_cycles + 64);

	logic clk_in = 1'b0;
	logic arst_n;
	logic sysen;
	logic wr_valid;
	logic rd_req;
	logic sysgood;
	logic down_check;
	pwr_seq_pkg::reg_addr_t wr_data;
	pwr_seq_pkg::reg_data_t rd_data;
	pwr_seq_pkg::rail_vec_t pg_drv;
	pwr_seq_pkg::rail_vec_t en;
	pwr_seq_pkg::rail_vec_t prev_en;
	pwr_seq_pkg::rail_vec_t hold_low;
	pwr_seq_pkg::rail_vec_t dropped;
	int cycles;
	int unsigned rng_state;
	int lag_cnt[pwr_seq_pkg::rail_count];
	int lag_target[pwr_seq_pkg::rail_count];
	int pg_high_cnt[pwr_seq_pkg::rail_count];

	// Expected DUT state kept by the test sequence
	pwr_seq_pkg::rail_vec_t rec_pg;
	pwr_seq_pkg::fault_t rec_err;
	logic rec_sysen;
	logic rec_sysgood;

	pwr_seq_pkg::reg_addr_t addr_list[12] = '{8'h00, 8'h01, 8'h03, 8'h05, 8'h06, 8'h07,
		8'h0C, 8'h0D, 8'h0E, 8'h0F, 8'h10, 8'h80};

	pwr_seq_top #(
		.delay_cycles(delay_cycles),
		.watch_cycles(watch_cycles)
	) dut0 (
		.clk_in(clk_in),
		.arst_n(arst_n),
		.sysen(sysen),
		.pg(pg_drv),
		.wr_valid(wr_valid),
		.wr_data(wr_data),
		.rd_req(rd_req),
		.rd_data(rd_data),
		.en(en),
		.sysgood(sysgood)
	);

	always #2 clk_in = ~clk_in;

	task automatic stop_with_failure();
		$display("Result: FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_byte(input string name, input pwr_seq_pkg::reg_data_t got_v,
		input pwr_seq_pkg::reg_data_t exp_v);
		if (got_v !== exp_v) begin
			$display("FAILED at %0t: %s is %02h, expected %02h", $time, name, got_v, exp_v);
			stop_with_failure();
		end
	endtask

	task automatic check_rails(input string name, input pwr_seq_pkg::rail_vec_t got_v,
		input pwr_seq_pkg::rail_vec_t exp_v);
		if (got_v !== exp_v) begin
			$display("FAILED at %0t: %s is %04h, expected %04h", $time, name, got_v, exp_v);
			stop_with_failure();
		end
	endtask

	task automatic check_status(input string name, input pwr_seq_pkg::status_t got_v,
		input pwr_seq_pkg::status_t exp_v);
		if (got_v !== exp_v) begin
			$display("FAILED at %0t: %s is %02h, expected %02h", $time, name, got_v, exp_v);
			stop_with_failure();
		end
	endtask

	function automatic int unsigned lcg_next(input int unsigned state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Expected register byte from the recorded pg, error flags and levels
	function automatic pwr_seq_pkg::reg_data_t expected_reg(input pwr_seq_pkg::reg_addr_t addr,
		input pwr_seq_pkg::rail_vec_t pg_rec, input pwr_seq_pkg::fault_t err_rec,
		input logic sysen_rec, input logic sysgood_rec);
		pwr_seq_pkg::status_t st;
		st = '0;
		st.sysgood = sysgood_rec;
		st.sysen = sysen_rec;
		st.fault = err_rec.fault;
		st.operation_err = err_rec.operation_err;
		st.wait_err = err_rec.wait_err;
		case (addr)
			8'h00: return 8'h06;
			8'h03: return 8'hFF;
			8'h05: return {1'b0, pg_rec[14:8]};
			8'h06: return pg_rec[7:0];
			8'h07: return st;
			8'h0C: return 8'h52;
			8'h0D: return 8'h43;
			8'h0E: return 8'h53;
			8'h0F: return 8'h20;
			default: return 8'h00;
		endcase
	endfunction

	function automatic pwr_seq_pkg::status_t expected_status();
		return expected_reg(pwr_seq_pkg::addr_status, rec_pg, rec_err, rec_sysen, rec_sysgood);
	endfunction

	// Caller is at a falling edge
	task automatic load_ptr(input pwr_seq_pkg::reg_addr_t addr);
		wr_valid = 1'b1;
		wr_data = addr;
		@(negedge clk_in);
		wr_valid = 1'b0;
	endtask

	task automatic read_reg(input pwr_seq_pkg::reg_addr_t addr,
		output pwr_seq_pkg::reg_data_t data);
		load_ptr(addr);
		@(negedge clk_in);
		data = rd_data;
	endtask

	task automatic read_next(output pwr_seq_pkg::reg_data_t data);
		rd_req = 1'b1;
		@(negedge clk_in);
		rd_req = 1'b0;
		@(negedge clk_in);
		data = rd_data;
	endtask

	// Poll status until it matches the record and confirm that it then holds
	task automatic wait_status();
		pwr_seq_pkg::reg_data_t st;
		do begin
			read_reg(pwr_seq_pkg::addr_status, st);
		end while (st !== expected_status());
		read_reg(pwr_seq_pkg::addr_status, st);
		check_status("status", st, expected_status());
	endtask

	task automatic check_pg_regs();
		pwr_seq_pkg::reg_data_t data;
		read_reg(pwr_seq_pkg::addr_pg_hi, data);
		check_byte("pg_hi", data, expected_reg(pwr_seq_pkg::addr_pg_hi, rec_pg, rec_err,
			rec_sysen, rec_sysgood));
		read_reg(pwr_seq_pkg::addr_pg_lo, data);
		check_byte("pg_lo", data, expected_reg(pwr_seq_pkg::addr_pg_lo, rec_pg, rec_err,
			rec_sysen, rec_sysgood));
	endtask

	task automatic wait_pg_zero();
		while (pg_drv != '0) begin
			@(negedge clk_in);
		end
	endtask

	task automatic wait_sysgood();
		while (!sysgood) begin
			@(negedge clk_in);
		end
	endtask

	// Supply model plus enable order monitor
	always @(negedge clk_in) begin : supply_model
		pwr_seq_pkg::rail_vec_t rose;
		pwr_seq_pkg::rail_vec_t fell;
		pwr_seq_pkg::rail_vec_t fell_exp;
		int idx;
		rose = en & ~prev_en;
		fell = prev_en & ~en;
		if (rose != '0) begin
			check_rails("en_rise", rose, prev_en + 1'b1);
			idx = 0;
			for (int i = 0; i < pwr_seq_pkg::rail_count; i++) begin
				if (rose[i]) idx = i;
			end
			if (idx > 0 && pg_high_cnt[idx-1] < delay_cycles) begin
				$display("Enable of rail %0d rose after only %0d cycles of good pg on rail %0d",
					idx, pg_high_cnt[idx-1], idx - 1);
				stop_with_failure();
			end
		end
		if (down_check && fell != '0) begin
			idx = 0;
			for (int i = 0; i < pwr_seq_pkg::rail_count; i++) begin
				if (prev_en[i]) idx = i;
			end
			fell_exp = '0;
			fell_exp[idx] = 1'b1;
			check_rails("en_fall", fell, fell_exp);
		end
		for (int i = 0; i < pwr_seq_pkg::rail_count; i++) begin
			if (dropped[i]) begin
				pg_drv[i] <= 1'b0;
			end else if (pg_drv[i] != en[i] && !(en[i] && hold_low[i])) begin
				if (lag_cnt[i] == 0) begin
					rng_state = lcg_next(rng_state);
					lag_target[i] = 2 + int'((rng_state >> 16) % 19);
				end
				lag_cnt[i]++;
				if (lag_cnt[i] >= lag_target[i]) begin
					pg_drv[i] <= en[i];
					lag_cnt[i] = 0;
				end
			end else begin
				lag_cnt[i] = 0;
			end
			pg_high_cnt[i] = pg_drv[i] ? pg_high_cnt[i] + 1 : 0;
		end
		prev_en = en;
	end

	always @(posedge clk_in) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeout_cycles);
			stop_with_failure();
		end
	end

	initial begin
		pwr_seq_pkg::reg_data_t got;
		arst_n = 1'b0;
		sysen = 1'b0;
		wr_valid = 1'b0;
		wr_data = '0;
		rd_req = 1'b0;
		pg_drv = '0;
		prev_en = '0;
		hold_low = '0;
		dropped = '0;
		down_check = 1'b0;
		cycles = 0;
		rng_state = 32'd7400;
		for (int i = 0; i < pwr_seq_pkg::rail_count; i++) begin
			lag_cnt[i] = 0;
			lag_target[i] = 0;
			pg_high_cnt[i] = 0;
		end
		repeat (8) @(negedge clk_in);
		check_rails("en", en, '0);
		check_byte("rd_data", rd_data, 8'h00);
		arst_n = 1'b1;

		// Power-up
		@(negedge clk_in);
		sysen = 1'b1;
		wait_sysgood();
		check_rails("en", en, '1);
		rec_pg = pg_drv;
		rec_err = '0;
		rec_sysen = 1'b1;
		rec_sysgood = 1'b1;

		// Identity and status readback
		foreach (addr_list[k]) begin
			read_reg(addr_list[k], got);
			check_byte($sformatf("rd_data@%02h", addr_list[k]), got,
				expected_reg(addr_list[k], rec_pg, rec_err, rec_sysen, rec_sysgood));
		end
		read_reg(pwr_seq_pkg::addr_vendor, got);
		for (int k = 1; k < 4; k++) begin
			read_next(got);
			check_byte($sformatf("rd_data@vendor+%0d", k), got,
				expected_reg(8'h0C + k, rec_pg, rec_err, rec_sysen, rec_sysgood));
		end

		// Operation error on rail 9
		dropped[9] <= 1'b1;
		repeat (2) @(negedge clk_in);
		rec_pg = pg_drv;
		rec_err = '{wait_err: 1'b0, operation_err: 1'b1, fault: 1'b1};
		rec_sysgood = 1'b0;
		wait_status();
		check_rails("en", en, '0);
		wait_pg_zero();
		check_pg_regs();

		// Watchdog on rail 5 after a clear
		dropped[9] <= 1'b0;
		hold_low[5] <= 1'b1;
		wait_pg_zero();
		load_ptr(pwr_seq_pkg::addr_clear);
		rec_err = '0;
		wait_status();
		while (!en[5]) begin
			@(negedge clk_in);
		end
		rec_pg = pg_drv;
		rec_err = '{wait_err: 1'b1, operation_err: 1'b0, fault: 1'b1};
		wait_status();
		check_rails("en", en, '0);
		wait_pg_zero();
		check_pg_regs();

		// Clear and full restart
		hold_low[5] <= 1'b0;
		wait_pg_zero();
		load_ptr(pwr_seq_pkg::addr_clear);
		rec_err = '0;
		wait_status();
		wait_sysgood();
		check_rails("en", en, '1);
		rec_sysgood = 1'b1;
		rec_pg = pg_drv;
		wait_status();
		check_pg_regs();

		// Power-down from the top rail
		down_check <= 1'b1;
		sysen = 1'b0;
		while (en != '0 || pg_drv != '0) begin
			@(negedge clk_in);
		end
		rec_sysen = 1'b0;
		rec_sysgood = 1'b0;
		wait_status();
		check_rails("en", en, '0);

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* pwr_seq_top.f */
verilog/pwr_seq_pkg.sv
verilog/rail_sequencer.sv
verilog/rail_timer.sv
verilog/fault_monitor.sv
verilog/seq_regs.sv
verilog/pwr_seq_top.sv
sim/pwr_seq_tb.sv
